// File: icache_top.f
+incdir+common
common/icache_pkg.sv
icache/icache_tag_ram.sv
icache/icache_data_ram.sv
icache/icache_lru.sv
icache/icache_ctrl.sv
source/icache_top.sv
sim/icache_mem_model.sv
sim/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_icache -f icache_top.f -o tb_icache_sim

./obj_dir/tb_icache_sim > sim.log
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sim/tb_icache.sv
// testbench for the instruction cache
// directed fetch tests against a bus memory model with random delays
// expected words come from the line contents function below

module tb_icache
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h2847_7c99;
    // worst fetch covers both bus waits and the FSM cycles
    localparam int FETCH_CYCLES    = 24;
    localparam int MAX_FETCHES     = 32;
    localparam int WATCHDOG_CYCLES = MAX_FETCHES * FETCH_CYCLES + 64;

    // A, B and C share index 0x12 and D sits at index 0x23
    localparam logic [31:0] LINE_A = 32'h0123_4120;
    localparam logic [31:0] LINE_B = 32'h0567_8120;
    localparam logic [31:0] LINE_C = 32'h09ab_c120;
    localparam logic [31:0] LINE_D = 32'h0024_6230;

    logic        clk = 1'b0;
    logic        reset;
    logic        valid;
    cache_req_t  req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;
    logic [31:0] line_addr;
    line_t       line_data;
    int unsigned reads;
    logic [31:0] rnd_state = SEED;

    logic [31:0] addr_list[$];
    int          max_lat;
    int          errors;
    int          checks;
    int          addr_moves = 0;
    logic        held_valid = 1'b0;
    logic [31:0] held_addr;

    icache_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    icache_mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .rand_bits (rnd_state),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .line_addr (line_addr),
        .line_data (line_data),
        .reads     (reads)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word k of a line is never zero thanks to the low 01
    function automatic word_t line_word(input logic [31:0] addr, input int k);
        return xorshift32({addr[31:4], 2'(k), 2'b01});
    endfunction

    function automatic line_t make_line(input logic [31:0] addr);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = line_word(addr, k);
        end
        return l;
    endfunction

    function automatic word_t expected_word(input logic [31:0] addr);
        return line_word(addr, int'(addr[3:2]));
    endfunction

    assign line_data = make_line(line_addr);

    always #4 clk = ~clk;

    // fresh random bits every cycle for the bus delays
    always @(posedge clk) begin
        rnd_state <= xorshift32(rnd_state);
    end

    // rd_addr must hold while a read waits for rd_rdy
    always @(negedge clk) begin
        if (rd_req && held_valid && (rd_addr !== held_addr)) begin
            addr_moves <= addr_moves + 1;
            $display("rd_addr changed from %h to %h while rd_req waited", held_addr, rd_addr);
        end
        held_valid <= rd_req;
        held_addr  <= rd_addr;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        valid = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    // valid is held over addr_list and words are checked in order
    // max_lat is the longest acceptance to data_ok distance in cycles
    task automatic run_fetches(input string name);
        int sent;
        int got;
        int cyc;
        int lat;
        int acc_cyc[$];
        sent    = 0;
        got     = 0;
        cyc     = 0;
        max_lat = 0;
        valid   = 1'b1;
        req     = addr_list[0];
        while (got < addr_list.size()) begin
            // bus responses change on the falling edge, look once they settle
            #1;
            if (data_ok) begin
                if (acc_cyc.size() == 0) begin
                    errors++;
                    $display("%s: data_ok came with no request outstanding", name);
                end else begin
                    lat = cyc - acc_cyc.pop_front();
                    if (lat > max_lat) begin
                        max_lat = lat;
                    end
                end
                check(name, expected_word(addr_list[got]), rdata);
                got++;
            end
            // taken at the coming rising edge
            if (valid && addr_ok) begin
                acc_cyc.push_back(cyc);
                sent++;
            end
            @(negedge clk);
            cyc++;
            if (sent < addr_list.size()) begin
                req = addr_list[sent];
            end else begin
                valid = 1'b0;
            end
        end
        // the last word gets exactly one data_ok
        #1;
        check({name, " extra data_ok"}, 32'd0, 32'(data_ok));
        @(negedge clk);
    endtask

    task automatic fetch_one(input string name, input logic [31:0] addr);
        addr_list.delete();
        addr_list.push_back(addr);
        run_fetches(name);
    endtask

    task automatic test_cold_miss();
        check("rd_req after reset", 32'd0, 32'(rd_req));
        fetch_one("cold miss", LINE_A + 32'd4);
        check("cold miss reads", 32'd1, reads);
        check("cold miss line address", LINE_A, line_addr);
    endtask

    task automatic test_hit_timing();
        int unsigned reads0;
        reads0 = reads;
        fetch_one("hit timing", LINE_A + 32'd12);
        check("hit timing reads", reads0, reads);
        check("hit latency", 32'd1, max_lat);
    endtask

    task automatic test_streaming();
        int unsigned reads0;
        fetch_one("stream fill", LINE_D);
        reads0 = reads;
        addr_list.delete();
        for (int i = 0; i < 4; i++) begin
            addr_list.push_back(LINE_A + 32'(i * 4));
        end
        for (int i = 0; i < 4; i++) begin
            addr_list.push_back(LINE_D + 32'(i * 4));
        end
        run_fetches("streaming hits");
        check("streaming reads", reads0, reads);
        check("streaming latency", 32'd1, max_lat);
    endtask

    // A sits in way 0 and B fills way 1, so touching A leaves B as victim
    task automatic test_replacement();
        int unsigned reads0;
        fetch_one("load B", LINE_B + 32'd8);
        fetch_one("touch A", LINE_A);
        fetch_one("load C", LINE_C + 32'd4);
        reads0 = reads;
        fetch_one("A kept", LINE_A + 32'd12);
        fetch_one("C kept", LINE_C);
        check("A and C resident", reads0, reads);
        fetch_one("B evicted", LINE_B);
        check("B evicted reads", reads0 + 32'd1, reads);
    endtask

    task automatic test_back_pressure();
        int unsigned reads0;
        reads0 = reads;
        addr_list.delete();
        // one word from each new line at indexes 0x40 and up
        for (int i = 0; i < 6; i++) begin
            addr_list.push_back(32'h00a0_0400 | (32'(i) << 4) | (32'(i & 3) << 2));
        end
        run_fetches("back-pressure");
        check("back-pressure reads", reads0 + 32'd6, reads);
        check("rd_addr moves", 32'd0, 32'(addr_moves));
    endtask

    task automatic test_reset_invalidation();
        apply_reset();
        check("rd_req after new reset", 32'd0, 32'(rd_req));
        check("data_ok after new reset", 32'd0, 32'(data_ok));
        fetch_one("after reset", LINE_A + 32'd4);
        check("miss after reset", 32'd1, reads);
    endtask

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the cache did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset  = 1'b1;
        valid  = 1'b0;
        req    = '0;
        errors = 0;
        checks = 0;
        apply_reset();
        test_cold_miss();
        test_hit_timing();
        test_streaming();
        test_replacement();
        test_back_pressure();
        test_reset_invalidation();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim/icache_mem_model.sv
// bus-side memory model for the instruction cache
// takes one line read at a time after a random rd_rdy wait,
// returns the line after a second random wait
// line contents come in from the testbench on line_data

module icache_mem_model
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] rand_bits,
    input  logic        rd_req,
    input  logic [31:0] rd_addr,
    output logic        rd_rdy,
    output logic        ret_valid,
    output line_t       ret_data,
    output logic [31:0] line_addr,
    input  line_t       line_data,
    output int unsigned reads
);
    timeunit 1ns;
    timeprecision 1ps;

    logic       ret_busy;
    logic       rdy_armed;
    logic       ret_armed;
    logic [2:0] rdy_cnt;
    logic [2:0] ret_cnt;

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
    end

    // transfers taken at the rising edge, same view as the DUT
    always @(posedge clk) begin
        if (reset) begin
            reads     <= 0;
            line_addr <= '0;
            ret_busy  <= 1'b0;
        end else if (rd_req && rd_rdy) begin
            reads     <= reads + 1;
            line_addr <= rd_addr;
            ret_busy  <= 1'b1;
        end else if (ret_valid) begin
            ret_busy <= 1'b0;
        end
    end

    // responses change on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            rdy_armed = 1'b0;
            ret_armed = 1'b0;
            rdy_cnt   = 3'd0;
            ret_cnt   = 3'd0;
        end else begin
            // rd_rdy lasts one cycle, the read goes at that edge
            if (rd_rdy) begin
                rd_rdy <= 1'b0;
            end else if (rd_req) begin
                if (!rdy_armed) begin
                    rdy_armed = 1'b1;
                    rdy_cnt   = rand_bits[2:0];
                end
                if (rdy_cnt == 3'd0) begin
                    rd_rdy    <= 1'b1;
                    rdy_armed = 1'b0;
                end else begin
                    rdy_cnt = rdy_cnt - 3'd1;
                end
            end
            // line goes back after its own wait, one cycle of ret_valid
            if (ret_valid) begin
                ret_valid <= 1'b0;
            end else if (ret_busy) begin
                if (!ret_armed) begin
                    ret_armed = 1'b1;
                    ret_cnt   = rand_bits[6:4];
                end
                if (ret_cnt == 3'd0) begin
                    ret_valid <= 1'b1;
                    ret_data  <= line_data;
                    ret_armed = 1'b0;
                end else begin
                    ret_cnt = ret_cnt - 3'd1;
                end
            end
        end
    end

endmodule

// File: source/icache_top.sv
// instruction cache top level
// two-way read-only cache, controller with tag stores, data banks and LRU
`include "icache_cfg.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // CPU side
    input  logic       valid,
    input  cache_req_t req,
    output logic       addr_ok,
    output logic       data_ok,
    output word_t      rdata,
    // bus side
    output logic       rd_req,
    output logic [`ICACHE_WORD_W-1:0] rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  line_t      ret_data
);

    cache_index_t rd_index;
    cache_tag_t   way0_tag;
    cache_tag_t   way1_tag;
    logic         way0_valid;
    logic         way1_valid;
    line_t        way0_line;
    line_t        way1_line;
    logic         fill_en;
    way_t         fill_way;
    cache_index_t fill_index;
    cache_tag_t   fill_tag;
    line_t        fill_line;
    way_t         victim_way;
    logic         touch_en;
    way_t         touch_way;

    icache_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .req        (req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .rd_index   (rd_index),
        .way0_tag   (way0_tag),
        .way1_tag   (way1_tag),
        .way0_valid (way0_valid),
        .way1_valid (way1_valid),
        .way0_line  (way0_line),
        .way1_line  (way1_line),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .victim_way (victim_way),
        .touch_en   (touch_en),
        .touch_way  (touch_way)
    );

    // way 0 tags, written when the fill picks way 0
    icache_tag_ram u_tag_way0 (
        .clk       (clk),
        .reset     (reset),
        .rd_index  (rd_index),
        .tag       (way0_tag),
        .tag_valid (way0_valid),
        .wr_en     (fill_en && (fill_way == 1'b0)),
        .wr_index  (fill_index),
        .wr_tag    (fill_tag)
    );

    icache_tag_ram u_tag_way1 (
        .clk       (clk),
        .reset     (reset),
        .rd_index  (rd_index),
        .tag       (way1_tag),
        .tag_valid (way1_valid),
        .wr_en     (fill_en && (fill_way == 1'b1)),
        .wr_index  (fill_index),
        .wr_tag    (fill_tag)
    );

    icache_data_ram u_data (
        .clk       (clk),
        .rd_index  (rd_index),
        .way0_line (way0_line),
        .way1_line (way1_line),
        .wr_en     (fill_en),
        .wr_way    (fill_way),
        .wr_index  (fill_index),
        .wr_line   (fill_line)
    );

    // victim lookup and touch both use the buffered index
    icache_lru u_lru (
        .clk         (clk),
        .reset       (reset),
        .index       (fill_index),
        .victim_way  (victim_way),
        .touch_en    (touch_en),
        .touch_index (fill_index),
        .touch_way   (touch_way)
    );

endmodule

// File: icache/icache_ctrl.sv
// instruction cache controller
// request buffer, hit compare, word select, miss FSM and refill control
// hits answer in the LOOKUP cycle, misses fetch one line over the bus
`include "icache_cfg.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    // CPU side
    input  logic         valid,
    input  cache_req_t   req,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,
    // bus side
    output logic         rd_req,
    output logic [`ICACHE_WORD_W-1:0] rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  line_t        ret_data,
    // tag and data read
    output cache_index_t rd_index,
    input  cache_tag_t   way0_tag,
    input  cache_tag_t   way1_tag,
    input  logic         way0_valid,
    input  logic         way1_valid,
    input  line_t        way0_line,
    input  line_t        way1_line,
    // fill
    output logic         fill_en,
    output way_t         fill_way,
    output cache_index_t fill_index,
    output cache_tag_t   fill_tag,
    output line_t        fill_line,
    // replacement
    input  way_t         victim_way,
    output logic         touch_en,
    output way_t         touch_way
);

    icache_state_e state;
    icache_state_e state_next;

    // request under lookup or miss
    cache_req_t buf_req;

    logic       hit_way0;
    logic       hit_way1;
    logic       hit;
    logic       lookup_hit;
    logic       accept;
    logic [1:0] word_sel;
    line_t      hit_line;

    // pick word sel out of a line
    function automatic word_t select_word(input line_t line, input logic [1:0] sel);
        word_t w;
        w = line[sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
        return w;
    endfunction

    // tag compare against the buffered request
    assign hit_way0   = way0_valid && (way0_tag == buf_req.tag);
    assign hit_way1   = way1_valid && (way1_tag == buf_req.tag);
    assign hit        = hit_way0 || hit_way1;
    assign lookup_hit = (state == LOOKUP) && hit;

    // new request taken in IDLE or behind a hit
    assign addr_ok = (state == IDLE) || lookup_hit;
    assign accept  = valid && addr_ok;

    // tag and data RAMs see the new index on acceptance
    assign rd_index = accept ? req.index : buf_req.index;

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_req <= req;
        end
    end

    // state register
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    state_next = MISS;
                end else if (!valid) begin
                    state_next = IDLE;
                end
            end
            MISS: begin
                // read handed to the bus
                if (rd_req && rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // registered read request
    // rises entering MISS, held until rd_rdy takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_req <= 1'b0;
        end else if ((state == LOOKUP) && !hit) begin
            rd_req <= 1'b1;
        end else if (rd_req && rd_rdy) begin
            rd_req <= 1'b0;
        end
    end

    // line address, offset zeroed
    assign rd_addr = {buf_req.tag, buf_req.index, {`ICACHE_OFFSET_W{1'b0}}};

    // word select, offset bits 3 to 2
    assign word_sel = buf_req.offset[`ICACHE_OFFSET_W-1:2];
    assign hit_line = hit_way1 ? way1_line : way0_line;

    // refill returns the word straight from the bus line
    assign data_ok = lookup_hit || ((state == REFILL) && ret_valid);
    assign rdata   = (state == REFILL) ? select_word(ret_data, word_sel)
                                       : select_word(hit_line, word_sel);

    // fill into the victim way at the buffered index
    assign fill_en    = (state == REFILL) && ret_valid;
    assign fill_way   = victim_way;
    assign fill_index = buf_req.index;
    assign fill_tag   = buf_req.tag;
    assign fill_line  = ret_data;

    // LRU update on hits and fills
    assign touch_en  = lookup_hit || fill_en;
    assign touch_way = (state == REFILL) ? victim_way : way_t'(hit_way1);

endmodule

// File: icache/icache_lru.sv
// replacement state
// one bit per set naming the least recently used way
`include "icache_cfg.svh"

module icache_lru
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  cache_index_t index,
    output way_t         victim_way,
    input  logic         touch_en,
    input  cache_index_t touch_index,
    input  way_t         touch_way
);

    // bit set means way 1 is the victim
    logic [`ICACHE_SETS-1:0] lru_bits;

    // combinational lookup, flops only
    assign victim_way = lru_bits[index];

    always_ff @(posedge clk) begin
        if (reset) begin
            // way 0 goes first in every set
            lru_bits <= '0;
        end else if (touch_en) begin
            // way just used becomes most recent, so the other one is next
            lru_bits[touch_index] <= ~touch_way;
        end
    end

endmodule

// File: icache/icache_data_ram.sv
// line storage for both ways
// four 32-bit banks per way, read together, written as a whole line
`include "icache_cfg.svh"

module icache_data_ram
    import icache_pkg::*;
(
    input  logic         clk,
    input  cache_index_t rd_index,
    output line_t        way0_line,
    output line_t        way1_line,
    input  logic         wr_en,
    input  way_t         wr_way,
    input  cache_index_t wr_index,
    input  line_t        wr_line
);

    // read lines assembled from the bank outputs
    line_t rd_line [2];

    for (genvar gw = 0; gw < 2; gw++) begin : gen_way
        for (genvar gb = 0; gb < `ICACHE_LINE_WORDS; gb++) begin : gen_bank
            // one bank holds word gb of every line in this way
            word_t bank_mem [`ICACHE_SETS];
            word_t bank_q;

            always_ff @(posedge clk) begin
                // fill hits all four banks of the chosen way at once
                if (wr_en && (wr_way == way_t'(gw))) begin
                    bank_mem[wr_index] <= wr_line[gb*`ICACHE_WORD_W +: `ICACHE_WORD_W];
                end
                bank_q <= bank_mem[rd_index];
            end

            assign rd_line[gw][gb*`ICACHE_WORD_W +: `ICACHE_WORD_W] = bank_q;
        end
    end

    assign way0_line = rd_line[0];
    assign way1_line = rd_line[1];

endmodule

// File: icache/icache_tag_ram.sv
// tag store for one way
// 256 tags with synchronous read, valid bits in resettable flops
`include "icache_cfg.svh"

module icache_tag_ram
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  cache_index_t rd_index,
    output cache_tag_t   tag,
    output logic         tag_valid,
    input  logic         wr_en,
    input  cache_index_t wr_index,
    input  cache_tag_t   wr_tag
);

    // tag array, maps onto block ram
    cache_tag_t tag_mem [`ICACHE_SETS];

    // one valid bit per set, cleared by reset
    logic [`ICACHE_SETS-1:0] valid_bits;

    // tag write and registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
        tag <= tag_mem[rd_index];
    end

    // valid bits follow the same read timing as the tags
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            tag_valid  <= 1'b0;
        end else begin
            if (wr_en) begin
                // a fill always leaves the set valid
                valid_bits[wr_index] <= 1'b1;
            end
            tag_valid <= valid_bits[rd_index];
        end
    end

endmodule

// File: common/icache_pkg.sv
// instruction cache shared types
// address fields, fetch request, line and word, FSM states
`include "icache_cfg.svh"

package icache_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]    cache_tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]  cache_index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] cache_offset_t;

    // one fetched instruction
    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    // full cache line, word 0 sits in the low bits
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // way select, 0 or 1
    typedef logic way_t;

    // fetch address as presented by the CPU
    // field order matches a plain 32-bit byte address
    typedef struct packed {
        cache_tag_t    tag;
        cache_index_t  index;
        cache_offset_t offset;
    } cache_req_t;

    // controller FSM
    // lookup checks tags, miss waits for the bus to take the read,
    // refill waits for the returning line
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } icache_state_e;

endpackage

// File: common/icache_cfg.svh
// instruction cache configuration
// geometry of the two-way cache and widths of the line-fill bus
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// address split, tag | index | byte offset
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     8
`define ICACHE_OFFSET_W    4

// 256 sets, two ways each
`define ICACHE_SETS        256

// line of four instruction words
`define ICACHE_LINE_WORDS  4
`define ICACHE_WORD_W      32
`define ICACHE_LINE_W      128

`endif
